/* isa_pkg.sv */
package isa_pkg;

    localparam int XLEN    = 32;
    localparam int GPR_NUM = 32;

    typedef logic [XLEN - 1 : 0] data_t;
    typedef logic [XLEN - 1 : 0] addr_t;
    typedef logic [XLEN - 1 : 0] inst_t;
    typedef logic [4 : 0]        gpr_id_t;
    typedef logic [6 : 0]        opcode_t;

    // RV32I base opcodes
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_FENCE  = 7'b0001111;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

endpackage

/* ctrl_pkg.sv */
package ctrl_pkg;

    typedef enum logic [4 : 0] {
        ALU_TYPE_ADD,
        ALU_TYPE_SUB,
        ALU_TYPE_SLL,
        ALU_TYPE_SLT,
        ALU_TYPE_SLTU,
        ALU_TYPE_XOR,
        ALU_TYPE_SRL,
        ALU_TYPE_SRA,
        ALU_TYPE_OR,
        ALU_TYPE_AND,
        ALU_TYPE_JALR,
        ALU_TYPE_BEQ,
        ALU_TYPE_BNE,
        ALU_TYPE_BLT,
        ALU_TYPE_BGE,
        ALU_TYPE_BLTU,
        ALU_TYPE_BGEU,
        ALU_TYPE_X
    } alu_type_e;

    typedef enum logic [1 : 0] {ALU_RS1_GPR, ALU_RS1_PC, ALU_RS1_X} alu_rs1_e;
    typedef enum logic [1 : 0] {ALU_RS2_GPR, ALU_RS2_IMM, ALU_RS2_X} alu_rs2_e;

    // J unconditional, B conditional, E fence
    typedef enum logic [1 : 0] {JMP_J, JMP_B, JMP_E, JMP_X} jmp_type_e;

    typedef enum logic [2 : 0] {
        RAM_BYT_1_S,
        RAM_BYT_2_S,
        RAM_BYT_4_S,
        RAM_BYT_1_U,
        RAM_BYT_2_U,
        RAM_BYT_4_U,
        RAM_BYT_X
    } ram_byt_e;

    // PC source writes the link address
    typedef enum logic [1 : 0] {
        REG_WR_SRC_ALU,
        REG_WR_SRC_MEM,
        REG_WR_SRC_PC,
        REG_WR_SRC_X
    } reg_wr_src_e;

    typedef struct packed {
        alu_type_e   alu_type;
        jmp_type_e   jmp_type;
        logic        ram_wr_en;
        logic        ram_rd_en;
        ram_byt_e    ram_byt;
        logic        reg_wr_en;
        reg_wr_src_e reg_wr_src;
        logic        halt;
    } ctrl_t;

    localparam ctrl_t CTRL_NOP = '{
        alu_type:   ALU_TYPE_X,
        jmp_type:   JMP_X,
        ram_wr_en:  1'b0,
        ram_rd_en:  1'b0,
        ram_byt:    RAM_BYT_X,
        reg_wr_en:  1'b0,
        reg_wr_src: REG_WR_SRC_X,
        halt:       1'b0
    };

endpackage

/* imm.sv */
`timescale 1ns/1ps

module imm
    import isa_pkg::*;
(
    input  inst_t i_inst,
    output data_t o_imm
);

    opcode_t w_opcode;

    assign w_opcode = i_inst[6 : 0];

    always_comb begin
        case (w_opcode)
            OP_JALR, OP_LOAD, OP_IMM: begin
                o_imm = {{20{i_inst[31]}}, i_inst[31 : 20]};
            end
            OP_STORE: begin
                o_imm = {{20{i_inst[31]}}, i_inst[31 : 25], i_inst[11 : 7]};
            end
            OP_BRANCH: begin
                o_imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30 : 25],
                         i_inst[11 : 8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                o_imm = {i_inst[31 : 12], 12'h0};
            end
            OP_JAL: begin
                o_imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19 : 12], i_inst[20],
                         i_inst[30 : 21], 1'b0};
            end
            default: o_imm = '0;
        endcase
    end

endmodule

/* idu.sv */
`timescale 1ns/1ps

module idu
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic    i_run,
    input  logic    i_halt,
    input  inst_t   i_inst,
    input  addr_t   i_pc,
    input  data_t   i_gpr_rs1_data,
    input  data_t   i_gpr_rs2_data,
    output ctrl_t   o_ctrl,
    output gpr_id_t o_gpr_rs1_id,
    output gpr_id_t o_gpr_rs2_id,
    output gpr_id_t o_gpr_rd_id,
    output data_t   o_rs1_data,
    output data_t   o_rs2_data,
    output data_t   o_store_data,
    output data_t   o_imm
);

    opcode_t    w_opcode;
    logic [2:0] w_funct3;
    logic [6:0] w_funct7;
    data_t      w_imm;
    ctrl_t      w_ctrl;
    alu_rs1_e   w_rs1_sel;
    alu_rs2_e   w_rs2_sel;
    logic       w_legal;
    logic       w_active;

    assign w_opcode = i_inst[6 : 0];
    assign w_funct3 = i_inst[14 : 12];
    assign w_funct7 = i_inst[31 : 25];

    imm u_imm (
        .i_inst(i_inst),
        .o_imm (w_imm)
    );

    always_comb begin
        w_ctrl    = CTRL_NOP;
        w_rs1_sel = ALU_RS1_X;
        w_rs2_sel = ALU_RS2_X;
        w_legal   = 1'b1;
        case (w_opcode)
            OP_LUI, OP_AUIPC: begin
                w_ctrl.alu_type   = ALU_TYPE_ADD;
                w_rs1_sel         = (w_opcode == OP_AUIPC) ? ALU_RS1_PC : ALU_RS1_X;
                w_rs2_sel         = ALU_RS2_IMM;
                w_ctrl.reg_wr_en  = 1'b1;
                w_ctrl.reg_wr_src = REG_WR_SRC_ALU;
            end
            OP_JAL, OP_JALR: begin
                w_ctrl.alu_type   = (w_opcode == OP_JALR) ? ALU_TYPE_JALR : ALU_TYPE_ADD;
                w_rs1_sel         = (w_opcode == OP_JALR) ? ALU_RS1_GPR : ALU_RS1_PC;
                w_rs2_sel         = ALU_RS2_IMM;
                w_ctrl.jmp_type   = JMP_J;
                w_ctrl.reg_wr_en  = 1'b1;
                w_ctrl.reg_wr_src = REG_WR_SRC_PC;
                w_legal           = (w_opcode == OP_JAL) || (w_funct3 == 3'b000);
            end
            OP_BRANCH: begin
                w_rs1_sel       = ALU_RS1_GPR;
                w_rs2_sel       = ALU_RS2_GPR;
                w_ctrl.jmp_type = JMP_B;
                case (w_funct3)
                    3'b000:  w_ctrl.alu_type = ALU_TYPE_BEQ;
                    3'b001:  w_ctrl.alu_type = ALU_TYPE_BNE;
                    3'b100:  w_ctrl.alu_type = ALU_TYPE_BLT;
                    3'b101:  w_ctrl.alu_type = ALU_TYPE_BGE;
                    3'b110:  w_ctrl.alu_type = ALU_TYPE_BLTU;
                    3'b111:  w_ctrl.alu_type = ALU_TYPE_BGEU;
                    default: w_legal = 1'b0;
                endcase
            end
            OP_LOAD: begin
                w_ctrl.alu_type   = ALU_TYPE_ADD;
                w_rs1_sel         = ALU_RS1_GPR;
                w_rs2_sel         = ALU_RS2_IMM;
                w_ctrl.ram_rd_en  = 1'b1;
                w_ctrl.reg_wr_en  = 1'b1;
                w_ctrl.reg_wr_src = REG_WR_SRC_MEM;
                case (w_funct3)
                    3'b000:  w_ctrl.ram_byt = RAM_BYT_1_S;
                    3'b001:  w_ctrl.ram_byt = RAM_BYT_2_S;
                    3'b010:  w_ctrl.ram_byt = RAM_BYT_4_S;
                    3'b100:  w_ctrl.ram_byt = RAM_BYT_1_U;
                    3'b101:  w_ctrl.ram_byt = RAM_BYT_2_U;
                    default: w_legal = 1'b0;
                endcase
            end
            OP_STORE: begin
                w_ctrl.alu_type  = ALU_TYPE_ADD;
                w_rs1_sel        = ALU_RS1_GPR;
                w_rs2_sel        = ALU_RS2_IMM;
                w_ctrl.ram_wr_en = 1'b1;
                case (w_funct3)
                    3'b000:  w_ctrl.ram_byt = RAM_BYT_1_U;
                    3'b001:  w_ctrl.ram_byt = RAM_BYT_2_U;
                    3'b010:  w_ctrl.ram_byt = RAM_BYT_4_U;
                    default: w_legal = 1'b0;
                endcase
            end
            OP_IMM, OP_REG: begin
                w_rs1_sel         = ALU_RS1_GPR;
                w_rs2_sel         = (w_opcode == OP_REG) ? ALU_RS2_GPR : ALU_RS2_IMM;
                w_ctrl.reg_wr_en  = 1'b1;
                w_ctrl.reg_wr_src = REG_WR_SRC_ALU;
                case (w_funct3)
                    3'b000: begin
                        w_ctrl.alu_type = (w_opcode == OP_REG && w_funct7[5]) ?
                                          ALU_TYPE_SUB : ALU_TYPE_ADD;
                    end
                    3'b001:  w_ctrl.alu_type = ALU_TYPE_SLL;
                    3'b010:  w_ctrl.alu_type = ALU_TYPE_SLT;
                    3'b011:  w_ctrl.alu_type = ALU_TYPE_SLTU;
                    3'b100:  w_ctrl.alu_type = ALU_TYPE_XOR;
                    3'b101:  w_ctrl.alu_type = w_funct7[5] ? ALU_TYPE_SRA : ALU_TYPE_SRL;
                    3'b110:  w_ctrl.alu_type = ALU_TYPE_OR;
                    default: w_ctrl.alu_type = ALU_TYPE_AND;
                endcase
                // funct7 only marks SUB and SRA; immediates elsewhere
                if (w_opcode == OP_REG) begin
                    w_legal = (w_funct7 == 7'h00) ||
                              ((w_funct7 == 7'h20) && (w_funct3 == 3'b000 || w_funct3 == 3'b101));
                end
                else if (w_funct3 == 3'b001 || w_funct3 == 3'b101) begin
                    w_legal = (w_funct7 == 7'h00) || ((w_funct7 == 7'h20) && w_funct3[2]);
                end
            end
            OP_FENCE: begin
                w_ctrl.jmp_type = JMP_E;
            end
            OP_SYSTEM: begin
                // ECALL or EBREAK only
                w_legal     = (i_inst[31 : 21] == 11'h0) && (i_inst[19 : 7] == 13'h0);
                w_ctrl.halt = 1'b1;
            end
            default: w_legal = 1'b0;
        endcase
        if (!w_legal) begin
            w_ctrl    = CTRL_NOP;
            w_rs1_sel = ALU_RS1_X;
            w_rs2_sel = ALU_RS2_X;
        end
    end

    assign w_active = i_run && !i_halt;

    assign o_ctrl       = w_active ? w_ctrl : CTRL_NOP;
    assign o_gpr_rs1_id = w_active ? i_inst[19 : 15] : '0;
    assign o_gpr_rs2_id = w_active ? i_inst[24 : 20] : '0;
    assign o_gpr_rd_id  = w_active ? i_inst[11 : 7]  : '0;

    // Operand selection
    always_comb begin
        o_rs1_data = '0;
        o_rs2_data = '0;
        if (w_active) begin
            case (w_rs1_sel)
                ALU_RS1_GPR: o_rs1_data = i_gpr_rs1_data;
                ALU_RS1_PC:  o_rs1_data = i_pc;
                default:     o_rs1_data = '0;
            endcase
            case (w_rs2_sel)
                ALU_RS2_GPR: o_rs2_data = i_gpr_rs2_data;
                ALU_RS2_IMM: o_rs2_data = w_imm;
                default:     o_rs2_data = '0;
            endcase
        end
    end

    assign o_store_data = w_active ? i_gpr_rs2_data : '0;
    assign o_imm        = w_active ? w_imm : '0;

endmodule

/* gpr.sv */
`timescale 1ns/1ps

module gpr
    import isa_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  gpr_id_t i_rs1_id,
    input  gpr_id_t i_rs2_id,
    input  logic    i_wr_en,
    input  gpr_id_t i_rd_id,
    input  data_t   i_wr_data,
    output data_t   o_rs1_data,
    output data_t   o_rs2_data
);

    data_t r_regs [GPR_NUM];

    // x0 is cleared by reset and never written
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < GPR_NUM; i++) begin
                r_regs[i] <= '0;
            end
        end
        else if (i_wr_en && (i_rd_id != '0)) begin
            r_regs[i_rd_id] <= i_wr_data;
        end
    end

    assign o_rs1_data = r_regs[i_rs1_id];
    assign o_rs2_data = r_regs[i_rs2_id];

endmodule

/* alu.sv */
`timescale 1ns/1ps

module alu
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  alu_type_e i_alu_type,
    input  data_t     i_a,
    input  data_t     i_b,
    output data_t     o_result,
    output logic      o_taken
);

    data_t      w_sum;
    logic [4:0] w_shamt;
    logic       w_eq;
    logic       w_lt;
    logic       w_ltu;

    assign w_sum   = i_a + i_b;
    assign w_shamt = i_b[4 : 0];
    assign w_eq    = (i_a == i_b);
    assign w_lt    = ($signed(i_a) < $signed(i_b));
    assign w_ltu   = (i_a < i_b);

    always_comb begin
        o_result = '0;
        o_taken  = 1'b0;
        case (i_alu_type)
            ALU_TYPE_ADD:  o_result = w_sum;
            ALU_TYPE_SUB:  o_result = i_a - i_b;
            ALU_TYPE_SLL:  o_result = i_a << w_shamt;
            ALU_TYPE_SLT:  o_result = {{(XLEN - 1){1'b0}}, w_lt};
            ALU_TYPE_SLTU: o_result = {{(XLEN - 1){1'b0}}, w_ltu};
            ALU_TYPE_XOR:  o_result = i_a ^ i_b;
            ALU_TYPE_SRL:  o_result = i_a >> w_shamt;
            ALU_TYPE_SRA:  o_result = $signed(i_a) >>> w_shamt;
            ALU_TYPE_OR:   o_result = i_a | i_b;
            ALU_TYPE_AND:  o_result = i_a & i_b;
            // Jump target, bit 0 dropped
            ALU_TYPE_JALR: o_result = {w_sum[XLEN - 1 : 1], 1'b0};
            ALU_TYPE_BEQ:  o_taken  = w_eq;
            ALU_TYPE_BNE:  o_taken  = !w_eq;
            ALU_TYPE_BLT:  o_taken  = w_lt;
            ALU_TYPE_BGE:  o_taken  = !w_lt;
            ALU_TYPE_BLTU: o_taken  = w_ltu;
            ALU_TYPE_BGEU: o_taken  = !w_ltu;
            default: begin
                o_result = '0;
                o_taken  = 1'b0;
            end
        endcase
    end

endmodule

/* ifu.sv */
`timescale 1ns/1ps

module ifu
    import isa_pkg::*;
    import ctrl_pkg::*;
#(
    parameter addr_t RESET_PC = '0
) (
    input  logic  i_clk,
    input  logic  i_reset,
    input  logic  i_run,
    input  ctrl_t i_ctrl,
    input  data_t i_imm,
    input  data_t i_alu_result,
    input  logic  i_taken,
    output addr_t o_pc,
    output logic  o_halt
);

    addr_t r_pc;
    addr_t w_pc_tgt;
    addr_t w_pc_next;
    logic  r_halt;

    assign w_pc_tgt = r_pc + i_imm;

    always_comb begin
        w_pc_next = r_pc + 32'd4;
        if (i_ctrl.halt) begin
            // Stop on the ECALL/EBREAK itself
            w_pc_next = r_pc;
        end
        else if (i_ctrl.jmp_type == JMP_J) begin
            w_pc_next = (i_ctrl.alu_type == ALU_TYPE_JALR) ? i_alu_result : w_pc_tgt;
        end
        else if ((i_ctrl.jmp_type == JMP_B) && i_taken) begin
            w_pc_next = w_pc_tgt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_pc   <= RESET_PC;
            r_halt <= 1'b0;
        end
        else if (i_run && !r_halt) begin
            r_pc <= w_pc_next;
            if (i_ctrl.halt) begin
                r_halt <= 1'b1;
            end
        end
    end

    assign o_pc   = r_pc;
    assign o_halt = r_halt;

endmodule

/* lsu.sv */
`timescale 1ns/1ps

module lsu
    import isa_pkg::*;
    import ctrl_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic  i_clk,
    input  ctrl_t i_ctrl,
    input  addr_t i_addr,
    input  data_t i_store_data,
    output data_t o_load_data
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    data_t              r_mem [DMEM_WORDS];
    logic [IDX_W - 1:0] w_idx;
    logic [4 : 0]       w_bit_ofs;
    logic [3 : 0]       w_be;
    data_t              w_wdata;
    data_t              w_rdata;
    data_t              w_ext;

    // Word index wraps around the array
    assign w_idx     = IDX_W'((i_addr >> 2) % addr_t'(DMEM_WORDS));
    assign w_bit_ofs = {i_addr[1 : 0], 3'b000};

    // Byte lanes for the store
    always_comb begin
        case (i_ctrl.ram_byt)
            RAM_BYT_1_S, RAM_BYT_1_U: w_be = 4'b0001 << i_addr[1 : 0];
            RAM_BYT_2_S, RAM_BYT_2_U: w_be = 4'b0011 << i_addr[1 : 0];
            default:                  w_be = 4'b1111;
        endcase
    end

    assign w_wdata = i_store_data << w_bit_ofs;

    always_ff @(posedge i_clk) begin
        if (i_ctrl.ram_wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (w_be[i]) begin
                    r_mem[w_idx][i * 8 +: 8] <= w_wdata[i * 8 +: 8];
                end
            end
        end
    end

    assign w_rdata = r_mem[w_idx] >> w_bit_ofs;

    always_comb begin
        case (i_ctrl.ram_byt)
            RAM_BYT_1_S: w_ext = {{24{w_rdata[7]}}, w_rdata[7 : 0]};
            RAM_BYT_2_S: w_ext = {{16{w_rdata[15]}}, w_rdata[15 : 0]};
            RAM_BYT_1_U: w_ext = {24'h0, w_rdata[7 : 0]};
            RAM_BYT_2_U: w_ext = {16'h0, w_rdata[15 : 0]};
            RAM_BYT_4_S, RAM_BYT_4_U: w_ext = w_rdata;
            default:     w_ext = '0;
        endcase
    end

    assign o_load_data = i_ctrl.ram_rd_en ? w_ext : '0;

endmodule

/* core_top.sv */
`timescale 1ns/1ps

module core_top
    import isa_pkg::*;
    import ctrl_pkg::*;
#(
    parameter addr_t RESET_PC   = '0,
    parameter int    DMEM_WORDS = 256
) (
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_run,
    input  inst_t   i_inst,
    output addr_t   o_pc,
    output logic    o_halt,
    output logic    o_wb_en,
    output gpr_id_t o_wb_rd,
    output data_t   o_wb_data
);

    ctrl_t   w_ctrl;
    gpr_id_t w_rs1_id;
    gpr_id_t w_rs2_id;
    gpr_id_t w_rd_id;
    data_t   w_gpr_rs1_data;
    data_t   w_gpr_rs2_data;
    data_t   w_alu_a;
    data_t   w_alu_b;
    data_t   w_store_data;
    data_t   w_imm;
    data_t   w_alu_result;
    logic    w_taken;
    data_t   w_load_data;
    data_t   w_wb_data;

    ifu #(
        .RESET_PC(RESET_PC)
    ) u_ifu (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_run       (i_run),
        .i_ctrl      (w_ctrl),
        .i_imm       (w_imm),
        .i_alu_result(w_alu_result),
        .i_taken     (w_taken),
        .o_pc        (o_pc),
        .o_halt      (o_halt)
    );

    idu u_idu (
        .i_run         (i_run),
        .i_halt        (o_halt),
        .i_inst        (i_inst),
        .i_pc          (o_pc),
        .i_gpr_rs1_data(w_gpr_rs1_data),
        .i_gpr_rs2_data(w_gpr_rs2_data),
        .o_ctrl        (w_ctrl),
        .o_gpr_rs1_id  (w_rs1_id),
        .o_gpr_rs2_id  (w_rs2_id),
        .o_gpr_rd_id   (w_rd_id),
        .o_rs1_data    (w_alu_a),
        .o_rs2_data    (w_alu_b),
        .o_store_data  (w_store_data),
        .o_imm         (w_imm)
    );

    gpr u_gpr (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_rs1_id  (w_rs1_id),
        .i_rs2_id  (w_rs2_id),
        .i_wr_en   (w_ctrl.reg_wr_en),
        .i_rd_id   (w_rd_id),
        .i_wr_data (w_wb_data),
        .o_rs1_data(w_gpr_rs1_data),
        .o_rs2_data(w_gpr_rs2_data)
    );

    alu u_alu (
        .i_alu_type(w_ctrl.alu_type),
        .i_a       (w_alu_a),
        .i_b       (w_alu_b),
        .o_result  (w_alu_result),
        .o_taken   (w_taken)
    );

    lsu #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_lsu (
        .i_clk       (i_clk),
        .i_ctrl      (w_ctrl),
        .i_addr      (w_alu_result),
        .i_store_data(w_store_data),
        .o_load_data (w_load_data)
    );

    // Write-back source
    always_comb begin
        case (w_ctrl.reg_wr_src)
            REG_WR_SRC_ALU: w_wb_data = w_alu_result;
            REG_WR_SRC_MEM: w_wb_data = w_load_data;
            REG_WR_SRC_PC:  w_wb_data = o_pc + 32'd4;
            default:        w_wb_data = '0;
        endcase
    end

    assign o_wb_en   = w_ctrl.reg_wr_en;
    assign o_wb_rd   = w_rd_id;
    assign o_wb_data = w_wb_data;

endmodule

/* tb_core.sv */
`timescale 1ns/1ps

module tb_core
    import isa_pkg::*;
();

    localparam int    PROG_LEN = 192;
    localparam inst_t NOP      = 32'h00000013;
    // addi x30, x30, 1 in slots that a jump or taken branch skips
    localparam inst_t FILLER   = {12'd1, 5'd30, 3'b000, 5'd30, OP_IMM};

    logic    i_clk;
    logic    i_reset;
    logic    i_run;
    inst_t   i_inst;
    addr_t   o_pc;
    logic    o_halt;
    logic    o_wb_en;
    gpr_id_t o_wb_rd;
    data_t   o_wb_data;

    inst_t       prog [PROG_LEN];
    int          prog_idx;
    logic [31:0] lfsr_state;

    // Shadow architectural state
    data_t      m_regs [32];
    logic [7:0] m_mem [1024];
    addr_t      m_pc;
    logic       m_halt;

    core_top #(
        .RESET_PC  (32'h0),
        .DMEM_WORDS(256)
    ) dut (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_run    (i_run),
        .i_inst   (i_inst),
        .o_pc     (o_pc),
        .o_halt   (o_halt),
        .o_wb_en  (o_wb_en),
        .o_wb_rd  (o_wb_rd),
        .o_wb_data(o_wb_data)
    );

    always #2 i_clk = ~i_clk;

    function automatic inst_t fetch(input addr_t pc);
        if (pc < addr_t'(PROG_LEN * 4)) begin
            return prog[int'(pc >> 2)];
        end
        return NOP;
    endfunction

    always_comb begin
        i_inst = fetch(o_pc);
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            // Taps 32 22 2 1
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic inst_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                    opcode_t op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic inst_t enc_s(logic [11:0] imm, int rs2, int rs1, logic [2:0] f3);
        return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], OP_STORE};
    endfunction

    function automatic inst_t enc_b(logic [12:0] imm, int rs1, int rs2, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic inst_t enc_u(logic [19:0] imm, int rd, opcode_t op);
        return {imm, 5'(rd), op};
    endfunction

    function automatic inst_t enc_j(logic [20:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OP_JAL};
    endfunction

    task automatic emit(input inst_t w);
        prog[prog_idx] = w;
        prog_idx++;
    endtask

    task automatic emit_branch(input logic [2:0] f3, input int rs1, input int rs2);
        emit(enc_b(13'd8, rs1, rs2, f3));
        emit(FILLER);
    endtask

    task automatic build_program();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [2:0]  kinds [6];
        int          rd;
        int          rs1;
        int          rs2;
        int          idx;
        kinds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        prog_idx = 0;
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = NOP;
        end
        for (int r = 1; r < 16; r++) begin
            emit(enc_u(20'(rand_bits(20)), r, OP_LUI));
            emit(enc_i(12'(rand_bits(12)), r, 3'b000, r, OP_IMM));
        end
        // Random ALU mix, x0 among the destinations
        for (int i = 0; i < 30; i++) begin
            f3 = 3'(rand_bits(3));
            f7 = 7'h00;
            if ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) != 0) begin
                f7 = 7'h20;
            end
            rd = int'(rand_bits(4));
            rs1 = int'(rand_bits(4));
            rs2 = int'(rand_bits(4));
            if (rand_bits(1) != 0) begin
                emit(enc_r(f7, rs2, rs1, f3, rd));
            end
            else begin
                imm = (f3 == 3'd1 || f3 == 3'd5) ? {f7, 5'(rand_bits(5))} : 12'(rand_bits(12));
                emit(enc_i(imm, rs1, f3, rd, OP_IMM));
            end
        end
        // Write to x0 that the x0 reads below must not see
        emit(enc_i(12'h7ff, 1, 3'b000, 0, OP_IMM));
        // Whole words first so every loaded byte is defined
        emit(enc_i(12'h100, 0, 3'b000, 20, OP_IMM));
        emit(enc_s(12'd0, 1, 20, 3'b010));
        emit(enc_s(12'd4, 2, 20, 3'b010));
        emit(enc_s(12'd8, 3, 20, 3'b010));
        emit(enc_s(12'd2, 4, 20, 3'b001));
        emit(enc_s(12'd6, 5, 20, 3'b001));
        emit(enc_s(12'd9, 6, 20, 3'b000));
        emit(enc_s(12'd11, 7, 20, 3'b000));
        for (int off = 0; off < 12; off++) begin
            emit(enc_i(12'(off), 20, 3'b000, 21, OP_LOAD));
            emit(enc_i(12'(off), 20, 3'b100, 21, OP_LOAD));
            if (off % 2 == 0) begin
                emit(enc_i(12'(off), 20, 3'b001, 21, OP_LOAD));
                emit(enc_i(12'(off), 20, 3'b101, 21, OP_LOAD));
            end
            if (off % 4 == 0) begin
                emit(enc_i(12'(off), 20, 3'b010, 21, OP_LOAD));
            end
        end
        // x10 equals x11, x13 is -5 and x14 is 7
        emit(enc_i(12'd0, 1, 3'b000, 10, OP_IMM));
        emit(enc_i(12'd0, 1, 3'b000, 11, OP_IMM));
        emit(enc_i(12'hffb, 0, 3'b000, 13, OP_IMM));
        emit(enc_i(12'd7, 0, 3'b000, 14, OP_IMM));
        for (int k = 0; k < 6; k++) begin
            emit_branch(kinds[k], 13, 14);
            emit_branch(kinds[k], 14, 13);
            emit_branch(kinds[k], 10, 11);
        end
        emit(enc_j(21'd8, 5));
        emit(FILLER);
        idx = prog_idx;
        // Odd base so the JALR target needs bit 0 cleared
        emit(enc_i(12'((idx + 2) * 4 + 1), 0, 3'b000, 6, OP_IMM));
        emit(enc_i(12'd4, 6, 3'b000, 7, OP_JALR));
        emit(FILLER);
        emit(enc_u(20'(rand_bits(20)), 8, OP_LUI));
        emit(enc_u(20'(rand_bits(20)), 9, OP_AUIPC));
        emit(enc_i(12'd0, 0, 3'b000, 0, OP_FENCE));
        emit(32'h00000073);
    endtask

    task automatic report_mismatch(input string name, input data_t got, input data_t exp);
        $display("Fail %s: got %h, expected %h", name, got, exp);
        $display("Checks failed");
        $fatal(1, "mismatch on %s", name);
    endtask

    always @(negedge i_clk) begin : model_check
        inst_t      ins;
        logic [2:0] f3;
        data_t      a;
        data_t      b;
        data_t      imm;
        data_t      addr;
        data_t      res;
        addr_t      pc_next;
        logic       wr;
        logic       taken;
        logic       halt_req;
        logic       active;
        if (i_reset) begin
            for (int r = 0; r < 32; r++) begin
                m_regs[r] = '0;
            end
            m_pc = '0;
            m_halt = 1'b0;
        end
        else begin
            active = i_run && !m_halt;
            ins = fetch(m_pc);
            f3 = ins[14:12];
            a = m_regs[ins[19:15]];
            b = m_regs[ins[24:20]];
            imm = {{20{ins[31]}}, ins[31:20]};
            res = '0;
            wr = 1'b0;
            taken = 1'b0;
            halt_req = 1'b0;
            pc_next = m_pc + 4;
            case (ins[6:0])
                OP_LUI: begin
                    wr = 1'b1;
                    res = {ins[31:12], 12'h0};
                end
                OP_AUIPC: begin
                    wr = 1'b1;
                    res = m_pc + {ins[31:12], 12'h0};
                end
                OP_JAL: begin
                    wr = 1'b1;
                    res = m_pc + 4;
                    pc_next = m_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                      ins[30:21], 1'b0};
                end
                OP_JALR: begin
                    wr = 1'b1;
                    res = m_pc + 4;
                    pc_next = (a + imm) & ~32'h1;
                end
                OP_BRANCH: begin
                    case (f3)
                        3'd0: taken = (a == b);
                        3'd1: taken = (a != b);
                        3'd4: taken = ($signed(a) < $signed(b));
                        3'd5: taken = ($signed(a) >= $signed(b));
                        3'd6: taken = (a < b);
                        default: taken = (a >= b);
                    endcase
                    if (taken) begin
                        pc_next = m_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                          ins[11:8], 1'b0};
                    end
                end
                OP_LOAD: begin
                    wr = 1'b1;
                    addr = a + imm;
                    res = {m_mem[10'(addr + 3)], m_mem[10'(addr + 2)],
                           m_mem[10'(addr + 1)], m_mem[addr[9:0]]};
                    case (f3[1:0])
                        2'b00: res = f3[2] ? {24'h0, res[7:0]} : {{24{res[7]}}, res[7:0]};
                        2'b01: res = f3[2] ? {16'h0, res[15:0]} : {{16{res[15]}}, res[15:0]};
                        default: ;
                    endcase
                end
                OP_STORE: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    for (int k = 0; k < (1 << f3[1:0]); k++) begin
                        if (active) begin
                            m_mem[10'(addr + k)] = b[8 * k +: 8];
                        end
                    end
                end
                OP_IMM, OP_REG: begin
                    wr = 1'b1;
                    if (ins[6:0] == OP_IMM) begin
                        b = imm;
                    end
                    case (f3)
                        3'd0: res = (ins[6:0] == OP_REG && ins[30]) ? a - b : a + b;
                        3'd1: res = a << b[4:0];
                        3'd2: res = 32'($signed(a) < $signed(b));
                        3'd3: res = 32'(a < b);
                        3'd4: res = a ^ b;
                        3'd5: begin
                            if (ins[30]) begin
                                res = $signed(a) >>> b[4:0];
                            end
                            else begin
                                res = a >> b[4:0];
                            end
                        end
                        3'd6: res = a | b;
                        default: res = a & b;
                    endcase
                end
                OP_SYSTEM: begin
                    halt_req = 1'b1;
                    pc_next = m_pc;
                end
                default: ;
            endcase
            assert (o_pc == m_pc)
                else report_mismatch("o_pc", o_pc, m_pc);
            assert (o_halt == m_halt)
                else report_mismatch("o_halt", 32'(o_halt), 32'(m_halt));
            assert (o_wb_en == (active && wr))
                else report_mismatch("o_wb_en", 32'(o_wb_en), 32'(active && wr));
            if (active && wr) begin
                assert (o_wb_rd == ins[11:7])
                    else report_mismatch("o_wb_rd", 32'(o_wb_rd), 32'(ins[11:7]));
                assert (o_wb_data == res)
                    else report_mismatch("o_wb_data", o_wb_data, res);
            end
            if (active) begin
                if (wr && ins[11:7] != 5'd0) begin
                    m_regs[ins[11:7]] = res;
                end
                m_pc = pc_next;
                m_halt = halt_req;
            end
        end
    end

    initial begin
        #(40 * PROG_LEN);
        $display("Timeout: the core did not reach its halt in time");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        i_clk = 1'b0;
        i_reset = 1'b1;
        i_run = 1'b0;
        lfsr_state = 32'h75d0bdce;
        build_program();
        repeat (8) @(posedge i_clk);
        i_reset <= 1'b0;
        i_run <= 1'b1;
        repeat (20) @(posedge i_clk);
        i_run <= 1'b0;
        repeat (6) @(posedge i_clk);
        i_run <= 1'b1;
        while (!o_halt) begin
            @(posedge i_clk);
        end
        // Halted core must stay put
        repeat (10) @(posedge i_clk);
        $display("All checks passed");
        $finish;
    end

endmodule

/* rvcore.f */
isa_pkg.sv
ctrl_pkg.sv
imm.sv
idu.sv
gpr.sv
alu.sv
ifu.sv
lsu.sv
core_top.sv
tb_core.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_core
FILELIST  ?= rvcore.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
